//--- rx_defines.svh
`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RX_ADC_W       14
`define RX_MIX_W       18
`define RX_CIC1_W      22
`define RX_OUT_W       24
`define RX_PHASE_W     48

// Quarter-wave table addressing and magnitude width
`define RX_NCO_LUT_W   10
`define RX_NCO_AMP_W   16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decimation chain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RX_CIC1_STAGES 3
`define RX_CIC1_DECIM  8
`define RX_CIC2_STAGES 3
`define RX_CIC2_DECIM  4

// Bit growth of each CIC is stages times log2 of the decimation
`define RX_CIC1_GROWTH (`RX_CIC1_STAGES * $clog2(`RX_CIC1_DECIM))
`define RX_CIC2_GROWTH (`RX_CIC2_STAGES * $clog2(`RX_CIC2_DECIM))

`endif

//--- rx_pkg.sv
`default_nettype none

`include "rx_defines.svh"

package rx_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sample types along the chain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic signed [`RX_ADC_W-1:0]  adc_sample_t;
	typedef logic signed [`RX_MIX_W-1:0]  mix_sample_t;
	typedef logic signed [`RX_CIC1_W-1:0] cic1_sample_t;
	typedef logic signed [`RX_OUT_W-1:0]  out_sample_t;

	// NCO phase increment and accumulator
	typedef logic [`RX_PHASE_W-1:0] phase_t;

	// Word presented to the CPU on a sample read
	typedef logic [15:0] rd_word_t;

	// Readout selection decoded from the read strobes
	typedef enum logic [1:0] {
		RD_PACKED,
		RD_I,
		RD_Q
	} rd_mode_e;

endpackage

`default_nettype wire

//--- rx_freq_load.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module rx_freq_load import rx_pkg::*; (
	input  wire logic        cpu_clk_i,
	input  wire logic        adc_clk,
	input  wire logic        arst_n_i,
	input  wire logic        rx_sel_i,
	input  wire logic        set_freq_hi_i,
	input  wire logic        set_freq_lo_i,
	input  wire logic [31:0] freq_data_i,
	output phase_t           phase_inc_o
);

	// Index 1 carries the high half and index 0 the low half
	localparam int HI = 1;
	localparam int LO = 0;

	logic [1:0] wr_req;
	logic [1:0] wr_tgl;
	logic [2:0] wr_sync [2];
	logic [1:0] load;
	logic       load_hi;
	logic       load_lo;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CPU clock domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A write only counts while this receiver is selected
	assign wr_req[HI] = rx_sel_i & set_freq_hi_i;
	assign wr_req[LO] = rx_sel_i & set_freq_lo_i;

	// Each accepted write flips its flag once
	always_ff @(posedge cpu_clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			wr_tgl <= '0;
		else
			wr_tgl <= wr_tgl ^ wr_req;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ADC clock domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Two flops resynchronize each flag and the third keeps the old level
	always_ff @(posedge adc_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int h = 0; h < 2; h++)
				wr_sync[h] <= '0;
		end
		else
		begin
			for (int h = 0; h < 2; h++)
				wr_sync[h] <= {wr_sync[h][1:0], wr_tgl[h]};
		end
	end

	// Any change of the resynchronized flag is one load
	always_comb
	begin
		for (int h = 0; h < 2; h++)
			load[h] = wr_sync[h][2] ^ wr_sync[h][1];
	end

	assign load_hi = load[HI];
	assign load_lo = load[LO];

	// The CPU keeps freq_data_i steady until the load has happened
	always_ff @(posedge adc_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			phase_inc_o <= '0;
		else
		begin
			if (load_hi)
				phase_inc_o[`RX_PHASE_W-1:16] <= freq_data_i;
			if (load_lo)
				phase_inc_o[15:0] <= freq_data_i[15:0];
		end
	end

endmodule

`default_nettype wire

//--- rx_nco_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module rx_nco_mixer import rx_pkg::*; (
	input  wire logic        adc_clk,
	input  wire logic        arst_n_i,
	input  wire phase_t      phase_inc_i,
	input  wire adc_sample_t adc_data_i,
	output mix_sample_t      mix_i_o,
	output mix_sample_t      mix_q_o
);

	localparam int LUT_W     = `RX_NCO_LUT_W;
	localparam int AMP_W     = `RX_NCO_AMP_W;
	localparam int LUT_DEPTH = 1 << LUT_W;
	localparam int PROD_W    = `RX_ADC_W + AMP_W + 1;
	// Full-scale cosine multiplies the sample by 2^15 and the result keeps 2^4 of it
	localparam int MIX_SHIFT = AMP_W - 1 - (`RX_MIX_W - `RX_ADC_W);
	localparam logic [AMP_W-1:0] FULL_SCALE = {1'b1, {(AMP_W-1){1'b0}}};
	localparam real FULL_R  = 2.0 ** (AMP_W - 1);
	localparam real HALF_PI = 1.5707963267948966;

	logic [AMP_W-1:0] sin_lut [LUT_DEPTH];

	phase_t                   phase_acc;
	logic [1:0]               quad;
	logic [LUT_W-1:0]         idx;
	logic [LUT_W-1:0]         idx_mirror;
	logic [AMP_W-1:0]         mag_direct;
	logic [AMP_W-1:0]         mag_mirror;
	logic [AMP_W-1:0]         cos_mag;
	logic [AMP_W-1:0]         sin_mag;
	logic                     cos_neg;
	logic                     sin_neg;

	adc_sample_t              sample_s1;
	logic [AMP_W-1:0]         cos_mag_s1;
	logic [AMP_W-1:0]         sin_mag_s1;
	logic                     cos_neg_s1;
	logic                     sin_neg_s1;

	logic signed [PROD_W-1:0] prod_i_s2;
	logic signed [PROD_W-1:0] prod_q_s2;
	logic                     neg_i_s2;
	logic                     neg_q_s2;

	logic signed [PROD_W-1:0] signed_i;
	logic signed [PROD_W-1:0] signed_q;
	logic signed [PROD_W-1:0] scaled_i;
	logic signed [PROD_W-1:0] scaled_q;

	// First quarter of a sine wave, entry k at angle k/LUT_DEPTH of a quarter turn
	initial
	begin
		for (int k = 0; k < LUT_DEPTH; k++)
			sin_lut[k] = AMP_W'($rtoi(FULL_R * $sin(HALF_PI * real'(k) / real'(LUT_DEPTH)) + 0.5));
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase and table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge adc_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			phase_acc <= '0;
		else
			phase_acc <= phase_acc + phase_inc_i;
	end

	assign quad       = phase_acc[`RX_PHASE_W-1 -: 2];
	assign idx        = phase_acc[`RX_PHASE_W-3 -: LUT_W];
	assign idx_mirror = -idx;

	// The mirrored read lands one past the table at index zero, which is exactly full scale
	assign mag_direct = sin_lut[idx];
	assign mag_mirror = (idx == '0) ? FULL_SCALE : sin_lut[idx_mirror];

	// Cosine and sine from quadrant symmetry, kept as sign and magnitude
	always_comb
	begin
		case (quad)
			2'd0:
			begin
				cos_mag = mag_mirror;
				cos_neg = 1'b0;
				sin_mag = mag_direct;
				sin_neg = 1'b0;
			end
			2'd1:
			begin
				cos_mag = mag_direct;
				cos_neg = 1'b1;
				sin_mag = mag_mirror;
				sin_neg = 1'b0;
			end
			2'd2:
			begin
				cos_mag = mag_mirror;
				cos_neg = 1'b1;
				sin_mag = mag_direct;
				sin_neg = 1'b1;
			end
			default:
			begin
				cos_mag = mag_direct;
				cos_neg = 1'b0;
				sin_mag = mag_mirror;
				sin_neg = 1'b1;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mixer pipeline
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// I is x times cosine and Q is minus x times sine
	always_ff @(posedge adc_clk)
	begin
		sample_s1  <= adc_data_i;
		cos_mag_s1 <= cos_mag;
		sin_mag_s1 <= sin_mag;
		cos_neg_s1 <= cos_neg;
		sin_neg_s1 <= sin_neg;

		prod_i_s2  <= PROD_W'(sample_s1) * PROD_W'($signed({1'b0, cos_mag_s1}));
		prod_q_s2  <= PROD_W'(sample_s1) * PROD_W'($signed({1'b0, sin_mag_s1}));
		neg_i_s2   <= cos_neg_s1;
		neg_q_s2   <= ~sin_neg_s1;

		mix_i_o    <= scaled_i[`RX_MIX_W-1:0];
		mix_q_o    <= scaled_q[`RX_MIX_W-1:0];
	end

	assign signed_i = neg_i_s2 ? -prod_i_s2 : prod_i_s2;
	assign signed_q = neg_q_s2 ? -prod_q_s2 : prod_q_s2;
	assign scaled_i = signed_i >>> MIX_SHIFT;
	assign scaled_q = signed_q >>> MIX_SHIFT;

endmodule

`default_nettype wire

//--- rx_cic_decim.sv
`timescale 1ns/1ps
`default_nettype none

module rx_cic_decim #(
	parameter int STAGES = 3,
	parameter int DECIM  = 8,
	parameter int IN_W   = 18,
	parameter int OUT_W  = 22,
	parameter int GROWTH = 9
) (
	input  wire logic                    adc_clk,
	input  wire logic                    arst_n_i,
	input  wire logic                    in_strobe_i,
	input  wire logic signed [IN_W-1:0]  in_i_i,
	input  wire logic signed [IN_W-1:0]  in_q_i,
	output logic                         out_strobe_o,
	output logic signed [OUT_W-1:0]      out_i_o,
	output logic signed [OUT_W-1:0]      out_q_o
);

	// Full-precision accumulator width and the low bits pruned at the output
	localparam int ACC_W = IN_W + GROWTH;
	localparam int DROP  = GROWTH - (OUT_W - IN_W);
	localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;

	// Rail 0 is I and rail 1 is Q
	logic signed [ACC_W-1:0] rail_in [2];
	logic signed [ACC_W-1:0] integ   [2][STAGES];
	logic signed [ACC_W-1:0] dly     [2][STAGES];
	logic signed [ACC_W-1:0] comb    [2][STAGES];
	logic [CNT_W-1:0]        dec_cnt;
	logic                    dec_tick;

	assign rail_in[0] = {{GROWTH{in_i_i[IN_W-1]}}, in_i_i};
	assign rail_in[1] = {{GROWTH{in_q_i[IN_W-1]}}, in_q_i};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Integrators at the input rate
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Wrap-around is harmless here since the combs undo it
	always_ff @(posedge adc_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int r = 0; r < 2; r++)
				for (int s = 0; s < STAGES; s++)
					integ[r][s] <= '0;
		end
		else if (in_strobe_i)
		begin
			for (int r = 0; r < 2; r++)
			begin
				integ[r][0] <= integ[r][0] + rail_in[r];
				for (int s = 1; s < STAGES; s++)
					integ[r][s] <= integ[r][s] + integ[r][s-1];
			end
		end
	end

	// Counts input strobes and wraps on the last one of each group
	always_ff @(posedge adc_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			dec_cnt <= '0;
		else if (in_strobe_i)
			dec_cnt <= dec_tick ? '0 : dec_cnt + 1'b1;
	end

	assign dec_tick = in_strobe_i && (dec_cnt == CNT_W'(DECIM - 1));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Combs at the output rate
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		for (int r = 0; r < 2; r++)
		begin
			comb[r][0] = integ[r][STAGES-1] - dly[r][0];
			for (int s = 1; s < STAGES; s++)
				comb[r][s] = comb[r][s-1] - dly[r][s];
		end
	end

	always_ff @(posedge adc_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			out_strobe_o <= 1'b0;
			for (int r = 0; r < 2; r++)
				for (int s = 0; s < STAGES; s++)
					dly[r][s] <= '0;
		end
		else
		begin
			out_strobe_o <= dec_tick;
			if (dec_tick)
			begin
				for (int r = 0; r < 2; r++)
				begin
					dly[r][0] <= integ[r][STAGES-1];
					for (int s = 1; s < STAGES; s++)
						dly[r][s] <= comb[r][s-1];
				end
			end
		end
	end

	// Outputs hold between strobes and keep the top OUT_W bits
	always_ff @(posedge adc_clk)
	begin
		if (dec_tick)
		begin
			out_i_o <= comb[0][STAGES-1][ACC_W-1:DROP];
			out_q_o <= comb[1][STAGES-1][ACC_W-1:DROP];
		end
	end

endmodule

`default_nettype wire

//--- rx_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module rx_channel import rx_pkg::*; (
	input  wire logic        adc_clk,
	input  wire logic        cpu_clk_i,
	input  wire logic        arst_n_i,
	input  wire adc_sample_t adc_data_i,
	input  wire logic        rx_sel_i,
	input  wire logic        set_freq_hi_i,
	input  wire logic        set_freq_lo_i,
	input  wire logic [31:0] freq_data_i,
	input  wire logic        rd_i_i,
	input  wire logic        rd_q_i,
	output rd_word_t         rx_dout_o,
	output logic             rx_avail_o
);

	phase_t       phase_inc;
	mix_sample_t  mix_i;
	mix_sample_t  mix_q;
	logic         cic1_avail;
	cic1_sample_t cic1_i;
	cic1_sample_t cic1_q;
	out_sample_t  out_i;
	out_sample_t  out_q;
	rd_mode_e     rd_mode;

	rx_freq_load rx_freq_load_inst (
		.cpu_clk_i     (cpu_clk_i),
		.adc_clk       (adc_clk),
		.arst_n_i      (arst_n_i),
		.rx_sel_i      (rx_sel_i),
		.set_freq_hi_i (set_freq_hi_i),
		.set_freq_lo_i (set_freq_lo_i),
		.freq_data_i   (freq_data_i),
		.phase_inc_o   (phase_inc)
	);

	rx_nco_mixer rx_nco_mixer_inst (
		.adc_clk     (adc_clk),
		.arst_n_i    (arst_n_i),
		.phase_inc_i (phase_inc),
		.adc_data_i  (adc_data_i),
		.mix_i_o     (mix_i),
		.mix_q_o     (mix_q)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decimate by 8 then by 4
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The mixer delivers a sample every cycle
	rx_cic_decim #(
		.STAGES (`RX_CIC1_STAGES),
		.DECIM  (`RX_CIC1_DECIM),
		.IN_W   (`RX_MIX_W),
		.OUT_W  (`RX_CIC1_W),
		.GROWTH (`RX_CIC1_GROWTH)
	) rx_cic1_inst (
		.adc_clk      (adc_clk),
		.arst_n_i     (arst_n_i),
		.in_strobe_i  (1'b1),
		.in_i_i       (mix_i),
		.in_q_i       (mix_q),
		.out_strobe_o (cic1_avail),
		.out_i_o      (cic1_i),
		.out_q_o      (cic1_q)
	);

	rx_cic_decim #(
		.STAGES (`RX_CIC2_STAGES),
		.DECIM  (`RX_CIC2_DECIM),
		.IN_W   (`RX_CIC1_W),
		.OUT_W  (`RX_OUT_W),
		.GROWTH (`RX_CIC2_GROWTH)
	) rx_cic2_inst (
		.adc_clk      (adc_clk),
		.arst_n_i     (arst_n_i),
		.in_strobe_i  (cic1_avail),
		.in_i_i       (cic1_i),
		.in_q_i       (cic1_q),
		.out_strobe_o (rx_avail_o),
		.out_i_o      (out_i),
		.out_q_o      (out_q)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// I read wins when both strobes are high
	always_comb
	begin
		if (rd_i_i)
			rd_mode = RD_I;
		else if (rd_q_i)
			rd_mode = RD_Q;
		else
			rd_mode = RD_PACKED;
	end

	always_comb
	begin
		case (rd_mode)
			RD_I:      rx_dout_o = out_i[15:0];
			RD_Q:      rx_dout_o = out_q[15:0];
			RD_PACKED: rx_dout_o = {out_i[`RX_OUT_W-1 -: 8], out_q[`RX_OUT_W-1 -: 8]};
			default:   rx_dout_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rx_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rx_assertions import rx_pkg::*; (
	input wire logic   adc_clk,
	input wire logic   arst_n_i,
	input wire logic   rx_avail_i,
	input wire phase_t phase_inc_i,
	input wire logic   load_hi_i,
	input wire logic   load_lo_i
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output strobe
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A sample is marked by a single cycle of avail
	avail_one_cycle: assert property (
		@(posedge adc_clk) disable iff (!arst_n_i)
		rx_avail_i |=> !rx_avail_i
	) else $error("rx_avail_o stayed high for more than one cycle");

	avail_low_in_reset: assert property (
		@(posedge adc_clk)
		!arst_n_i |-> !rx_avail_i
	) else $error("rx_avail_o high while reset is asserted");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase increment register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Without a resynchronized load the increment must hold its value
	phase_only_on_load: assert property (
		@(posedge adc_clk) disable iff (!arst_n_i)
		!$past(load_hi_i || load_lo_i) |-> $stable(phase_inc_i)
	) else $error("Phase increment changed without a load pulse");

endmodule

`default_nettype wire

//--- tb_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rx import rx_pkg::*; ();

	localparam int SETTLE_N       = 4;
	localparam int CHECK_N        = 2;
	localparam int N_WINDOWS      = 8;
	localparam int AVAIL_WAIT_MAX = 72;
	localparam int CYCLE_LIMIT    = (N_WINDOWS * (SETTLE_N + CHECK_N) + 6) * 32 + 1000;
	localparam logic [31:0] SEED  = 32'he5e10d6c;

	logic        adc_clk = 1'b0;
	logic        cpu_clk_i = 1'b0;
	logic        arst_n_i;
	adc_sample_t adc_data_i;
	logic        rx_sel_i;
	logic        set_freq_hi_i;
	logic        set_freq_lo_i;
	logic [31:0] freq_data_i;
	logic        rd_i_i;
	logic        rd_q_i;
	rd_word_t    rx_dout_o;
	logic        rx_avail_o;

	logic [31:0] rng_state;
	adc_sample_t dc_x;

	always #50 adc_clk = ~adc_clk;
	always #35 cpu_clk_i = ~cpu_clk_i;

	rx_channel rx_channel_inst (
		.adc_clk       (adc_clk),
		.cpu_clk_i     (cpu_clk_i),
		.arst_n_i      (arst_n_i),
		.adc_data_i    (adc_data_i),
		.rx_sel_i      (rx_sel_i),
		.set_freq_hi_i (set_freq_hi_i),
		.set_freq_lo_i (set_freq_lo_i),
		.freq_data_i   (freq_data_i),
		.rd_i_i        (rd_i_i),
		.rd_q_i        (rd_q_i),
		.rx_dout_o     (rx_dout_o),
		.rx_avail_o    (rx_avail_o)
	);

	bind rx_channel rx_assertions rx_assertions_inst (
		.adc_clk     (adc_clk),
		.arst_n_i    (arst_n_i),
		.rx_avail_i  (rx_avail_o),
		.phase_inc_i (phase_inc),
		.load_hi_i   (rx_freq_load_inst.load_hi),
		.load_lo_i   (rx_freq_load_inst.load_lo)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic random_sample(output adc_sample_t x);
		rng_state = xorshift32(rng_state);
		x = rng_state[13:0];
	endtask

	// DC at phase 0 gains 2^4 in the mixer, 2^4 in CIC1 and 2^2 in CIC2
	function automatic out_sample_t expected_dc_i(input adc_sample_t x);
		int xi;
		xi = int'(x);
		return out_sample_t'(xi * 1024);
	endfunction

	task automatic abort_run(input string why);
		$display("TESTBENCH FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(input string name, input rd_word_t got, input rd_word_t exp);
		if (got !== exp)
		begin
			$display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Read word mismatch on %s", name);
		end
	endtask

	task automatic check_sample(input string name, input out_sample_t got,
			input out_sample_t exp);
		if (got !== exp)
		begin
			$display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Sample mismatch on %s", name);
		end
	endtask

	// Returns at the falling edge where rx_avail_o is seen high
	task automatic wait_avail(output int cycles);
		cycles = 0;
		do
		begin
			@(negedge adc_clk);
			cycles++;
			if (cycles > AVAIL_WAIT_MAX)
				abort_run("rx_avail_o did not pulse within the expected time");
		end
		while (rx_avail_o !== 1'b1);
	endtask

	task automatic read_word(input rd_mode_e mode, output rd_word_t word);
		rd_i_i = (mode == RD_I);
		rd_q_i = (mode == RD_Q);
		@(negedge adc_clk);
		word = rx_dout_o;
	endtask

	// Both read strobes high at once
	task automatic read_both_strobes(output rd_word_t word);
		rd_i_i = 1'b1;
		rd_q_i = 1'b1;
		@(negedge adc_clk);
		word = rx_dout_o;
	endtask

	// One cycle strobe in the CPU domain, data held until the load has landed
	task automatic write_freq(input logic sel, input logic hi, input logic lo,
			input logic [31:0] data);
		@(negedge cpu_clk_i);
		rx_sel_i      = sel;
		set_freq_hi_i = hi;
		set_freq_lo_i = lo;
		freq_data_i   = data;
		@(negedge cpu_clk_i);
		rx_sel_i      = 1'b0;
		set_freq_hi_i = 1'b0;
		set_freq_lo_i = 1'b0;
		repeat (8) @(negedge adc_clk);
	endtask

	// Drives a DC level, lets the chain settle and checks all three read words
	task automatic expect_dc(input adc_sample_t x, input out_sample_t exp_i,
			input out_sample_t exp_q);
		int       gap;
		rd_word_t w_i;
		rd_word_t w_q;
		rd_word_t w_p;
		rd_word_t w_b;
		@(negedge adc_clk);
		adc_data_i = x;
		repeat (SETTLE_N) wait_avail(gap);
		for (int n = 0; n < CHECK_N; n++)
		begin
			wait_avail(gap);
			read_word(RD_I, w_i);
			read_word(RD_Q, w_q);
			read_both_strobes(w_b);
			read_word(RD_PACKED, w_p);
			// The packed top byte and the low word rebuild the full sample
			check_sample("rx_dout_o I sample", {w_p[15:8], w_i}, exp_i);
			check_sample("rx_dout_o Q sample", {w_p[7:0], w_q}, exp_q);
			// With both strobes high the I read takes priority
			check_word("rx_dout_o rd_i_i and rd_q_i", w_b, exp_i[15:0]);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_and_spacing();
		int gap;
		arst_n_i = 1'b0;
		repeat (8)
		begin
			@(negedge adc_clk);
			if (rx_avail_o !== 1'b0)
				abort_run("rx_avail_o went high while reset was asserted");
		end
		arst_n_i = 1'b1;
		wait_avail(gap);
		for (int k = 0; k < 4; k++)
		begin
			wait_avail(gap);
			if (gap != 32)
				abort_run($sformatf("rx_avail_o pulses came %0d cycles apart, not 32", gap));
		end
	endtask

	task automatic test_dc_readout();
		for (int k = 0; k < 2; k++)
		begin
			random_sample(dc_x);
			expect_dc(dc_x, expected_dc_i(dc_x), '0);
		end
	endtask

	task automatic test_packed_negative();
		for (int k = 0; k < 2; k++)
		begin
			random_sample(dc_x);
			dc_x[13] = 1'b1;
			expect_dc(dc_x, expected_dc_i(dc_x), '0);
		end
	endtask

	// A quarter-turn write without the select must not reach the NCO
	task automatic test_unselected_write();
		write_freq(1'b0, 1'b1, 1'b0, 32'h4000_0000);
		expect_dc(dc_x, expected_dc_i(dc_x), '0);
	endtask

	// The upper data bits would give a quarter turn if the low write leaked into the high half
	task automatic test_low_half_only();
		write_freq(1'b1, 1'b0, 1'b1, 32'h4000_0100);
		expect_dc(dc_x, expected_dc_i(dc_x), '0);
		write_freq(1'b1, 1'b0, 1'b1, 32'h4000_0000);
		expect_dc(dc_x, expected_dc_i(dc_x), '0);
	endtask

	// Eight mixed samples at a quarter turn sum to zero on both rails
	task automatic test_quarter_turn();
		write_freq(1'b1, 1'b1, 1'b0, 32'h4000_0000);
		expect_dc(dc_x, '0, '0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Run control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge adc_clk);
			cycles++;
		end
		$display("TESTBENCH FAILED");
		$fatal(1, "Run exceeded %0d adc_clk cycles", CYCLE_LIMIT);
	end

	initial
	begin
		arst_n_i      = 1'b0;
		adc_data_i    = '0;
		rx_sel_i      = 1'b0;
		set_freq_hi_i = 1'b0;
		set_freq_lo_i = 1'b0;
		freq_data_i   = '0;
		rd_i_i        = 1'b0;
		rd_q_i        = 1'b0;
		rng_state     = SEED;
		dc_x          = '0;

		test_reset_and_spacing();
		test_dc_readout();
		test_packed_negative();
		test_unselected_write();
		test_low_half_only();
		test_quarter_turn();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
rx_pkg.sv
rx_freq_load.sv
rx_nco_mixer.sv
rx_cic_decim.sv
rx_channel.sv
rx_assertions.sv
tb_rx.sv

//--- run.sh
#!/bin/sh
# Builds the receive channel testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_rx -o tb_rx_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tb_rx_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit "$status"
fi

exit 0
